/* hdl/dxl_pkg.sv */
package dxl_pkg;

	// wishbone register map, word addresses
	localparam int WB_DATA_W = 32;
	localparam logic [1:0] REG_ID        = 2'd0;
	localparam logic [1:0] REG_WRITE_CMD = 2'd1;
	localparam logic [1:0] REG_READ_CMD  = 2'd2;
	localparam logic [1:0] REG_STATUS    = 2'd3;

	// uart bit timing, 1 Mbit at 50 MHz
	localparam int CLKS_PER_BIT = 50;
	localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [BIT_CNT_W-1:0] BIT_LAST = BIT_CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [BIT_CNT_W-1:0] BIT_HALF = BIT_CNT_W'(CLKS_PER_BIT / 2 - 1);

	// reply window and the quiet time that ends a rejected reply
	localparam int REPLY_TIMEOUT_CYCLES = 16384;
	localparam int TIMER_W = $clog2(REPLY_TIMEOUT_CYCLES);
	localparam logic [TIMER_W-1:0] REPLY_LOAD = TIMER_W'(REPLY_TIMEOUT_CYCLES - 1);
	localparam logic [TIMER_W-1:0] SILENCE_LOAD = TIMER_W'(20 * CLKS_PER_BIT - 1);

	// protocol 2.0 framing
	localparam logic [7:0] HDR_0       = 8'hFF;
	localparam logic [7:0] HDR_1       = 8'hFF;
	localparam logic [7:0] HDR_2       = 8'hFD;
	localparam logic [7:0] HDR_RSV     = 8'h00;
	localparam logic [7:0] INST_READ   = 8'h02;
	localparam logic [7:0] INST_WRITE  = 8'h03;
	localparam logic [7:0] INST_STATUS = 8'h55;
	localparam logic [15:0] CRC_POLY   = 16'h8005;
	localparam int TABLE_ADDR_W = 16;
	localparam int VALUE_W = 16;

	// control table entries that span two bytes
	localparam logic [15:0] TBL_MODEL_NUMBER     = 16'd0;
	localparam logic [15:0] TBL_CW_ANGLE_LIMIT   = 16'd6;
	localparam logic [15:0] TBL_CCW_ANGLE_LIMIT  = 16'd8;
	localparam logic [15:0] TBL_MAX_TORQUE       = 16'd15;
	localparam logic [15:0] TBL_GOAL_POSITION    = 16'd30;
	localparam logic [15:0] TBL_GOAL_SPEED       = 16'd32;
	localparam logic [15:0] TBL_GOAL_TORQUE      = 16'd35;
	localparam logic [15:0] TBL_PRESENT_POSITION = 16'd37;
	localparam logic [15:0] TBL_PRESENT_SPEED    = 16'd39;
	localparam logic [15:0] TBL_PRESENT_LOAD     = 16'd41;
	localparam logic [15:0] TBL_PUNCH            = 16'd51;

	// status word layout
	localparam int STAT_BUSY      = 31;
	localparam int STAT_TIMEOUT   = 30;
	localparam int STAT_VALID     = 29;
	localparam int STAT_ERR_LSB   = 16;
	localparam int STAT_VALUE_LSB = 0;

	// sequencer states
	localparam logic [2:0] ST_IDLE    = 3'd0;
	localparam logic [2:0] ST_TX_LOAD = 3'd1;
	localparam logic [2:0] ST_TX_WAIT = 3'd2;
	localparam logic [2:0] ST_RX      = 3'd3;
	localparam logic [2:0] ST_DRAIN   = 3'd4;

	function automatic logic is_two_byte(input logic [TABLE_ADDR_W-1:0] addr);
		return addr == TBL_MODEL_NUMBER || addr == TBL_CW_ANGLE_LIMIT ||
			addr == TBL_CCW_ANGLE_LIMIT || addr == TBL_MAX_TORQUE ||
			addr == TBL_GOAL_POSITION || addr == TBL_GOAL_SPEED ||
			addr == TBL_GOAL_TORQUE || addr == TBL_PRESENT_POSITION ||
			addr == TBL_PRESENT_SPEED || addr == TBL_PRESENT_LOAD ||
			addr == TBL_PUNCH;
	endfunction

endpackage

/* hdl/dxl_crc16.sv */
`timescale 1ns/1ps

module dxl_crc16 (
	input  logic        clock,
	input  logic        reset,
	input  logic        i_clear,
	input  logic        i_en,
	input  logic [7:0]  i_byte,
	output logic [15:0] o_crc
);

	// msb first, no reflection, matches the byte table used by the servos
	function automatic logic [15:0] crc_step(input logic [15:0] crc, input logic [7:0] data);
		logic [15:0] c;
		c = crc;
		for (int i = 7; i >= 0; i--) begin
			if (c[15] ^ data[i]) begin
				c = {c[14:0], 1'b0} ^ dxl_pkg::CRC_POLY;
			end else begin
				c = {c[14:0], 1'b0};
			end
		end
		return c;
	endfunction

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			o_crc <= 16'h0000;
		end else if (i_clear) begin
			o_crc <= 16'h0000;
		end else if (i_en) begin
			o_crc <= crc_step(o_crc, i_byte);
		end
	end

endmodule

/* hdl/dxl_uart_tx.sv */
`timescale 1ns/1ps

module dxl_uart_tx (
	input  logic       clock,
	input  logic       reset,
	input  logic       i_start,
	input  logic [7:0] i_byte,
	output logic       o_busy,
	output logic       o_done,
	output logic       o_serial
);

	logic [8:0] shreg;
	logic [3:0] bit_idx;
	logic [dxl_pkg::BIT_CNT_W-1:0] clk_cnt;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			o_busy <= 1'b0;
			o_done <= 1'b0;
			o_serial <= 1'b1;
			shreg <= '1;
			bit_idx <= 4'd0;
			clk_cnt <= '0;
		end else begin
			o_done <= 1'b0;
			if (!o_busy) begin
				if (i_start) begin
					// start bit goes out now, data and stop bit wait in the shifter
					o_busy <= 1'b1;
					o_serial <= 1'b0;
					shreg <= {1'b1, i_byte};
					bit_idx <= 4'd0;
					clk_cnt <= '0;
				end
			end else if (clk_cnt == dxl_pkg::BIT_LAST) begin
				clk_cnt <= '0;
				if (bit_idx == 4'd9) begin
					// end of stop bit
					o_busy <= 1'b0;
					o_done <= 1'b1;
				end else begin
					o_serial <= shreg[0];
					shreg <= {1'b1, shreg[8:1]};
					bit_idx <= bit_idx + 4'd1;
				end
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

endmodule

/* hdl/dxl_uart_rx.sv */
`timescale 1ns/1ps

module dxl_uart_rx (
	input  logic       clock,
	input  logic       reset,
	input  logic       i_serial,
	output logic       o_valid,
	output logic [7:0] o_byte
);

	logic meta;
	logic line;
	logic line_d;
	logic active;
	logic [3:0] bit_idx;
	logic [dxl_pkg::BIT_CNT_W-1:0] clk_cnt;

	// two-flop synchronizer plus one more stage for edge detection
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			meta <= 1'b1;
			line <= 1'b1;
			line_d <= 1'b1;
		end else begin
			meta <= i_serial;
			line <= meta;
			line_d <= line;
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			active <= 1'b0;
			bit_idx <= 4'd0;
			clk_cnt <= '0;
			o_valid <= 1'b0;
			o_byte <= 8'h00;
		end else begin
			o_valid <= 1'b0;
			if (!active) begin
				if (line_d && !line) begin
					active <= 1'b1;
					bit_idx <= 4'd0;
					clk_cnt <= '0;
				end
			end else if (bit_idx == 4'd0) begin
				// middle of the start bit, a glitch has gone high again
				if (clk_cnt == dxl_pkg::BIT_HALF) begin
					clk_cnt <= '0;
					if (line) begin
						active <= 1'b0;
					end else begin
						bit_idx <= 4'd1;
					end
				end else begin
					clk_cnt <= clk_cnt + 1'b1;
				end
			end else if (clk_cnt == dxl_pkg::BIT_LAST) begin
				clk_cnt <= '0;
				if (bit_idx == 4'd9) begin
					// mid stop bit, framing error drops the byte
					active <= 1'b0;
					o_valid <= line;
				end else begin
					o_byte <= {line, o_byte[7:1]};
					bit_idx <= bit_idx + 4'd1;
				end
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

endmodule

/* hdl/dxl_controller.sv */
`timescale 1ns/1ps

module dxl_controller (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          i_wb_cyc,
	input  logic                          i_wb_stb,
	input  logic                          i_wb_we,
	input  logic [1:0]                    i_wb_adr,
	input  logic [dxl_pkg::WB_DATA_W-1:0] i_wb_dat,
	output logic [dxl_pkg::WB_DATA_W-1:0] o_wb_dat,
	output logic                          o_wb_ack,
	output logic                          o_tx_start,
	output logic [7:0]                    o_tx_byte,
	input  logic                          i_tx_busy,
	input  logic                          i_tx_done,
	input  logic                          i_rx_valid,
	input  logic [7:0]                    i_rx_byte,
	output logic                          o_crc_clear,
	output logic                          o_crc_en,
	output logic [7:0]                    o_crc_byte,
	input  logic [15:0]                   i_crc_value,
	output logic                          o_tx_en
);

	logic [2:0] state;
	logic busy;
	logic [7:0] id_reg;
	logic cmd_is_read;
	logic [dxl_pkg::TABLE_ADDR_W-1:0] cmd_addr;
	logic [dxl_pkg::VALUE_W-1:0] cmd_value;
	logic stat_valid;
	logic stat_timeout;
	logic [7:0] stat_error;
	logic [dxl_pkg::VALUE_W-1:0] stat_value;
	logic [dxl_pkg::WB_DATA_W-1:0] status_word;

	logic wb_req;
	logic cmd_wr;
	logic wb_go;

	logic two_byte;
	logic [3:0] tx_idx;
	logic [3:0] tx_crc_idx;
	logic [3:0] tx_last_idx;
	logic [7:0] tx_byte;

	logic [15:0] rx_idx;
	logic [15:0] rx_len;
	logic [15:0] rx_crc_lo;
	logic [15:0] rx_crc_hi;
	logic [7:0] crc_lo_q;
	logic [7:0] hdr_exp;
	logic rx_fail;
	logic rx_last;
	logic [dxl_pkg::TIMER_W-1:0] wait_cnt;

	assign busy = (state != dxl_pkg::ST_IDLE);

	// bus side, command writes stall while a transaction runs
	assign wb_req = i_wb_cyc && i_wb_stb && !o_wb_ack;
	assign cmd_wr = i_wb_we &&
		(i_wb_adr == dxl_pkg::REG_WRITE_CMD || i_wb_adr == dxl_pkg::REG_READ_CMD);
	assign wb_go = wb_req && !(cmd_wr && busy);

	always_comb begin
		status_word = '0;
		status_word[dxl_pkg::STAT_BUSY] = busy;
		status_word[dxl_pkg::STAT_TIMEOUT] = stat_timeout;
		status_word[dxl_pkg::STAT_VALID] = stat_valid;
		status_word[dxl_pkg::STAT_ERR_LSB +: 8] = stat_error;
		status_word[dxl_pkg::STAT_VALUE_LSB +: dxl_pkg::VALUE_W] = stat_value;
	end

	// instruction packet, each byte picked from the latched fields
	assign two_byte = dxl_pkg::is_two_byte(cmd_addr);
	assign tx_crc_idx = two_byte ? 4'd12 : 4'd11;
	assign tx_last_idx = tx_crc_idx + 4'd1;

	always_comb begin
		case (tx_idx)
			4'd0: tx_byte = dxl_pkg::HDR_0;
			4'd1: tx_byte = dxl_pkg::HDR_1;
			4'd2: tx_byte = dxl_pkg::HDR_2;
			4'd3: tx_byte = dxl_pkg::HDR_RSV;
			4'd4: tx_byte = id_reg;
			4'd5: tx_byte = two_byte ? 8'd7 : 8'd6;
			4'd6: tx_byte = 8'h00;
			4'd7: tx_byte = cmd_is_read ? dxl_pkg::INST_READ : dxl_pkg::INST_WRITE;
			4'd8: tx_byte = cmd_addr[7:0];
			4'd9: tx_byte = cmd_addr[15:8];
			4'd10: tx_byte = cmd_value[7:0];
			4'd11: tx_byte = two_byte ? cmd_value[15:8] : i_crc_value[7:0];
			4'd12: tx_byte = two_byte ? i_crc_value[7:0] : i_crc_value[15:8];
			default: tx_byte = i_crc_value[15:8];
		endcase
	end

	// status packet checks on the byte in flight
	assign rx_crc_lo = rx_len + 16'd5;
	assign rx_crc_hi = rx_len + 16'd6;
	assign rx_last = (rx_idx > 16'd8) && (rx_idx == rx_crc_hi);

	always_comb begin
		case (rx_idx[1:0])
			2'd0: hdr_exp = dxl_pkg::HDR_0;
			2'd1: hdr_exp = dxl_pkg::HDR_1;
			2'd2: hdr_exp = dxl_pkg::HDR_2;
			default: hdr_exp = dxl_pkg::HDR_RSV;
		endcase
	end

	always_comb begin
		rx_fail = 1'b0;
		if (rx_idx < 16'd4) begin
			rx_fail = (i_rx_byte != hdr_exp);
		end else if (rx_idx == 16'd4) begin
			rx_fail = (i_rx_byte != id_reg);
		end else if (rx_idx == 16'd6) begin
			// instruction and error byte at least, plus the crc
			rx_fail = ({i_rx_byte, rx_len[7:0]} < 16'd4);
		end else if (rx_idx == 16'd7) begin
			rx_fail = (i_rx_byte != dxl_pkg::INST_STATUS);
		end else if (rx_idx == 16'd8) begin
			rx_fail = (i_rx_byte != 8'h00);
		end else if (rx_last) begin
			rx_fail = ({i_rx_byte, crc_lo_q} != i_crc_value);
		end
	end

	assign o_tx_start = (state == dxl_pkg::ST_TX_LOAD);
	assign o_tx_byte = tx_byte;
	assign o_crc_clear = (state == dxl_pkg::ST_IDLE) ||
		(state == dxl_pkg::ST_TX_WAIT && i_tx_done && tx_idx == tx_last_idx);
	assign o_crc_en = (state == dxl_pkg::ST_TX_LOAD && tx_idx < tx_crc_idx) ||
		(state == dxl_pkg::ST_RX && i_rx_valid &&
		(rx_idx < 16'd7 || rx_idx < rx_crc_lo));
	assign o_crc_byte = (state == dxl_pkg::ST_RX) ? i_rx_byte : tx_byte;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= dxl_pkg::ST_IDLE;
			o_wb_ack <= 1'b0;
			o_wb_dat <= '0;
			o_tx_en <= 1'b0;
			id_reg <= 8'h00;
			cmd_is_read <= 1'b0;
			cmd_addr <= '0;
			cmd_value <= '0;
			stat_valid <= 1'b0;
			stat_timeout <= 1'b0;
			stat_error <= 8'h00;
			stat_value <= '0;
			tx_idx <= 4'd0;
			rx_idx <= 16'd0;
			rx_len <= 16'd0;
			crc_lo_q <= 8'h00;
			wait_cnt <= '0;
		end else begin
			o_wb_ack <= wb_go;
			if (wb_go) begin
				case (i_wb_adr)
					dxl_pkg::REG_ID: o_wb_dat <= {24'h000000, id_reg};
					dxl_pkg::REG_STATUS: o_wb_dat <= status_word;
					default: o_wb_dat <= '0;
				endcase
				if (i_wb_we && i_wb_adr == dxl_pkg::REG_ID) begin
					id_reg <= i_wb_dat[7:0];
				end
			end

			case (state)
				dxl_pkg::ST_IDLE: begin
					if (wb_go && cmd_wr) begin
						cmd_is_read <= (i_wb_adr == dxl_pkg::REG_READ_CMD);
						cmd_addr <= i_wb_dat[31:16];
						cmd_value <= i_wb_dat[15:0];
						stat_valid <= 1'b0;
						stat_timeout <= 1'b0;
						stat_error <= 8'h00;
						stat_value <= '0;
						tx_idx <= 4'd0;
						state <= dxl_pkg::ST_TX_LOAD;
					end
				end
				dxl_pkg::ST_TX_LOAD: begin
					o_tx_en <= 1'b1;
					state <= dxl_pkg::ST_TX_WAIT;
				end
				dxl_pkg::ST_TX_WAIT: begin
					if (i_tx_done) begin
						if (tx_idx != tx_last_idx) begin
							tx_idx <= tx_idx + 4'd1;
							state <= dxl_pkg::ST_TX_LOAD;
						end else begin
							// line released after the last stop bit
							o_tx_en <= 1'b0;
							if (cmd_is_read) begin
								rx_idx <= 16'd0;
								wait_cnt <= dxl_pkg::REPLY_LOAD;
								state <= dxl_pkg::ST_RX;
							end else begin
								stat_valid <= 1'b1;
								state <= dxl_pkg::ST_IDLE;
							end
						end
					end
				end
				dxl_pkg::ST_RX: begin
					if (wait_cnt != '0) begin
						wait_cnt <= wait_cnt - 1'b1;
					end
					if (i_rx_valid) begin
						rx_idx <= rx_idx + 16'd1;
						if (rx_idx == 16'd5) begin
							rx_len[7:0] <= i_rx_byte;
						end
						if (rx_idx == 16'd6) begin
							rx_len[15:8] <= i_rx_byte;
						end
						if (rx_idx == 16'd8) begin
							stat_error <= i_rx_byte;
						end
						// parameters arrive little-endian, only the first two are kept
						if (rx_idx == 16'd9 && rx_idx < rx_crc_lo) begin
							stat_value[7:0] <= i_rx_byte;
						end
						if (rx_idx == 16'd10 && rx_idx < rx_crc_lo) begin
							stat_value[15:8] <= i_rx_byte;
						end
						if (rx_idx == rx_crc_lo) begin
							crc_lo_q <= i_rx_byte;
						end
						if (rx_fail) begin
							wait_cnt <= dxl_pkg::SILENCE_LOAD;
							state <= dxl_pkg::ST_DRAIN;
						end else if (rx_last) begin
							stat_valid <= 1'b1;
							state <= dxl_pkg::ST_IDLE;
						end
					end else if (wait_cnt == '0) begin
						stat_timeout <= 1'b1;
						state <= dxl_pkg::ST_IDLE;
					end
				end
				dxl_pkg::ST_DRAIN: begin
					// every byte restarts the quiet window
					if (i_rx_valid) begin
						wait_cnt <= dxl_pkg::SILENCE_LOAD;
					end else if (wait_cnt == '0) begin
						state <= dxl_pkg::ST_IDLE;
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				default: state <= dxl_pkg::ST_IDLE;
			endcase
		end
	end

endmodule

/* hdl/dxl_bus_master.sv */
`timescale 1ns/1ps

module dxl_bus_master (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          i_wb_cyc,
	input  logic                          i_wb_stb,
	input  logic                          i_wb_we,
	input  logic [1:0]                    i_wb_adr,
	input  logic [dxl_pkg::WB_DATA_W-1:0] i_wb_dat,
	output logic [dxl_pkg::WB_DATA_W-1:0] o_wb_dat,
	output logic                          o_wb_ack,
	input  logic                          i_rx,
	output logic                          o_tx,
	output logic                          o_tx_en
);

	logic       tx_start;
	logic [7:0] tx_byte;
	logic       tx_busy;
	logic       tx_done;
	logic       rx_valid;
	logic [7:0] rx_byte;
	logic       crc_clear;
	logic       crc_en;
	logic [7:0] crc_byte;
	logic [15:0] crc_value;

	dxl_controller dxl_controller_i (
		.clock       (clock),
		.reset       (reset),
		.i_wb_cyc    (i_wb_cyc),
		.i_wb_stb    (i_wb_stb),
		.i_wb_we     (i_wb_we),
		.i_wb_adr    (i_wb_adr),
		.i_wb_dat    (i_wb_dat),
		.o_wb_dat    (o_wb_dat),
		.o_wb_ack    (o_wb_ack),
		.o_tx_start  (tx_start),
		.o_tx_byte   (tx_byte),
		.i_tx_busy   (tx_busy),
		.i_tx_done   (tx_done),
		.i_rx_valid  (rx_valid),
		.i_rx_byte   (rx_byte),
		.o_crc_clear (crc_clear),
		.o_crc_en    (crc_en),
		.o_crc_byte  (crc_byte),
		.i_crc_value (crc_value),
		.o_tx_en     (o_tx_en)
	);

	// one checksum engine shared by the outgoing and the incoming packet
	dxl_crc16 dxl_crc16_i (
		.clock   (clock),
		.reset   (reset),
		.i_clear (crc_clear),
		.i_en    (crc_en),
		.i_byte  (crc_byte),
		.o_crc   (crc_value)
	);

	dxl_uart_tx dxl_uart_tx_i (
		.clock    (clock),
		.reset    (reset),
		.i_start  (tx_start),
		.i_byte   (tx_byte),
		.o_busy   (tx_busy),
		.o_done   (tx_done),
		.o_serial (o_tx)
	);

	dxl_uart_rx dxl_uart_rx_i (
		.clock    (clock),
		.reset    (reset),
		.i_serial (i_rx),
		.o_valid  (rx_valid),
		.o_byte   (rx_byte)
	);

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic o_clock,
	output logic o_reset
);

	// 4 ns period
	initial begin
		o_clock = 1'b0;
		forever #2 o_clock = ~o_clock;
	end

	// released on a falling edge, clear of the DUT's sampling edge
	initial begin
		o_reset = 1'b1;
		repeat (3) @(posedge o_clock);
		@(negedge o_clock);
		o_reset = 1'b0;
	end

endmodule

/* bench/dxl_bus_master_chk.sv */
`timescale 1ns/1ps

module dxl_bus_master_chk (
	input logic clock,
	input logic reset,
	input logic i_wb_cyc,
	input logic i_wb_stb,
	input logic o_wb_ack,
	input logic o_tx_start,
	input logic i_tx_busy,
	input logic i_rx_valid,
	input logic o_tx_en
);

	// an ack answers a request that was on the bus one clock earlier
	ack_needs_request: assert property (@(posedge clock) disable iff (reset)
		$rose(o_wb_ack) |-> $past(i_wb_cyc && i_wb_stb))
		else $error("o_wb_ack rose without cyc and stb");

	ack_single_cycle: assert property (@(posedge clock) disable iff (reset)
		o_wb_ack |=> !o_wb_ack)
		else $error("o_wb_ack high for two clocks");

	start_when_idle: assert property (@(posedge clock) disable iff (reset)
		o_tx_start |-> !i_tx_busy)
		else $error("tx start raised while the transmitter is busy");

	// half duplex, the driver must be off while a reply arrives
	rx_with_driver_off: assert property (@(posedge clock) disable iff (reset)
		i_rx_valid |-> !o_tx_en)
		else $error("reply byte received while o_tx_en is high");

endmodule

bind dxl_controller dxl_bus_master_chk dxl_bus_master_chk_i (
	.clock      (clock),
	.reset      (reset),
	.i_wb_cyc   (i_wb_cyc),
	.i_wb_stb   (i_wb_stb),
	.o_wb_ack   (o_wb_ack),
	.o_tx_start (o_tx_start),
	.i_tx_busy  (i_tx_busy),
	.i_rx_valid (i_rx_valid),
	.o_tx_en    (o_tx_en)
);

/* bench/dxl_bus_master_tb.sv */
`timescale 1ns/1ps

module dxl_bus_master_tb;

	localparam int MAX_TESTS = 16;
	localparam int MAX_BYTES = 16;
	localparam int BIT_CLKS = dxl_pkg::CLKS_PER_BIT;
	// keeps the longest reply inside the reply window
	localparam int MAX_GAP_BITS = 180;

	logic clock;
	logic reset;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [1:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic wb_ack;
	logic rx_line;
	logic tx_line;
	logic tx_en;

	int n_tests;
	int t_kind [MAX_TESTS];
	int t_id [MAX_TESTS];
	int t_addr [MAX_TESTS];
	int t_value [MAX_TESTS];
	int t_pcnt [MAX_TESTS];
	int t_rcnt [MAX_TESTS];
	int t_valid [MAX_TESTS];
	int t_timeout [MAX_TESTS];
	int t_err [MAX_TESTS];
	int t_rvalue [MAX_TESTS];
	logic [7:0] t_pkt [MAX_TESTS][MAX_BYTES];
	logic [7:0] t_reply [MAX_TESTS][MAX_BYTES];
	int packets_seen;
	int cycles = 0;
	int cycle_limit = 0;

	tb_clock tb_clock_i (
		.o_clock (clock),
		.o_reset (reset)
	);

	dxl_bus_master dxl_bus_master_i (
		.clock    (clock),
		.reset    (reset),
		.i_wb_cyc (wb_cyc),
		.i_wb_stb (wb_stb),
		.i_wb_we  (wb_we),
		.i_wb_adr (wb_adr),
		.i_wb_dat (wb_dat_w),
		.o_wb_dat (wb_dat_r),
		.o_wb_ack (wb_ack),
		.i_rx     (rx_line),
		.o_tx     (tx_line),
		.o_tx_en  (tx_en)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("TB FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycle_limit != 0 && cycles > cycle_limit) begin
			abort_run("simulation ran past its cycle limit, the DUT stopped responding");
		end
	end

	task automatic load_golden();
		int fd;
		int rc;
		int k;
		int v;
		string line;
		fd = $fopen("bench/dxl_golden.txt", "r");
		if (fd == 0) begin
			abort_run("could not open bench/dxl_golden.txt");
		end
		// two comment lines describe the columns
		if ($fgets(line, fd) == 0 || $fgets(line, fd) == 0) begin
			abort_run("golden file is shorter than its column description");
		end
		n_tests = 0;
		while (n_tests < MAX_TESTS && $fscanf(fd, "%h", v) == 1) begin
			t_kind[n_tests] = v;
			rc = $fscanf(fd, "%h %h %h %h", t_id[n_tests], t_addr[n_tests],
				t_value[n_tests], t_pcnt[n_tests]);
			if (rc != 4 || t_pcnt[n_tests] > MAX_BYTES) begin
				abort_run("golden file has a bad command field or packet length");
			end
			rc = 0;
			for (k = 0; k < t_pcnt[n_tests]; k++) begin
				rc += $fscanf(fd, "%h", v);
				t_pkt[n_tests][k] = v[7:0];
			end
			rc += $fscanf(fd, "%h", t_rcnt[n_tests]);
			if (rc != t_pcnt[n_tests] + 1 || t_rcnt[n_tests] > MAX_BYTES) begin
				abort_run("golden file has a short packet or a bad reply length");
			end
			rc = 0;
			for (k = 0; k < t_rcnt[n_tests]; k++) begin
				rc += $fscanf(fd, "%h", v);
				t_reply[n_tests][k] = v[7:0];
			end
			rc += $fscanf(fd, "%h %h %h %h", t_valid[n_tests], t_timeout[n_tests],
				t_err[n_tests], t_rvalue[n_tests]);
			if (rc != t_rcnt[n_tests] + 4) begin
				abort_run("golden file has a short reply or expected status");
			end
			n_tests++;
		end
		$fclose(fd);
		if (n_tests == 0) begin
			abort_run("golden file holds no tests");
		end
	endtask

	task automatic wait_ack();
		do @(negedge clock); while (wb_ack !== 1'b1);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic write_reg(input logic [1:0] adr, input logic [31:0] data);
		@(negedge clock);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b1;
		wb_adr = adr;
		wb_dat_w = data;
		wait_ack();
	endtask

	task automatic read_reg(input logic [1:0] adr, output logic [31:0] data);
		@(negedge clock);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b0;
		wb_adr = adr;
		wait_ack();
		data = wb_dat_r;
	endtask

	// servo side deserializer, samples mid-bit on falling edges
	task automatic capture_byte(output logic [7:0] b);
		do @(negedge clock); while (tx_line !== 1'b0);
		repeat (BIT_CLKS / 2) @(negedge clock);
		if (tx_line !== 1'b0) begin
			abort_run("start bit on o_tx did not last half a bit time");
		end
		check_value("o_tx_en", tx_en, 1);
		for (int i = 0; i < 8; i++) begin
			repeat (BIT_CLKS) @(negedge clock);
			b[i] = tx_line;
			check_value("o_tx_en", tx_en, 1);
		end
		repeat (BIT_CLKS) @(negedge clock);
		if (tx_line !== 1'b1) begin
			abort_run("stop bit on o_tx is missing");
		end
		check_value("o_tx_en", tx_en, 1);
	endtask

	task automatic send_byte(input logic [7:0] b);
		rx_line = 1'b0;
		repeat (BIT_CLKS) @(negedge clock);
		for (int i = 0; i < 8; i++) begin
			rx_line = b[i];
			repeat (BIT_CLKS) @(negedge clock);
		end
		rx_line = 1'b1;
		repeat (BIT_CLKS) @(negedge clock);
	endtask

	task automatic run_servo(input int n);
		int reps;
		int gap;
		logic [7:0] b;
		reps = (t_kind[n] == 2) ? 2 : 1;
		for (int r = 0; r < reps; r++) begin
			for (int k = 0; k < t_pcnt[n]; k++) begin
				capture_byte(b);
				check_value("o_tx packet byte", b, t_pkt[n][k]);
			end
			packets_seen++;
		end
		if (t_rcnt[n] > 0) begin
			gap = 1 + int'($urandom % MAX_GAP_BITS);
			repeat (gap * BIT_CLKS) @(negedge clock);
			for (int k = 0; k < t_rcnt[n]; k++) begin
				send_byte(t_reply[n][k]);
			end
		end
	endtask

	task automatic drive_host(input int n);
		logic [31:0] data;
		logic [31:0] cmd;
		logic [1:0] cmd_reg;
		write_reg(dxl_pkg::REG_ID, t_id[n]);
		read_reg(dxl_pkg::REG_ID, data);
		check_value("id register", data, t_id[n] & 32'hFF);
		cmd_reg = (t_kind[n] == 1) ? dxl_pkg::REG_READ_CMD : dxl_pkg::REG_WRITE_CMD;
		cmd = {t_addr[n][15:0], t_value[n][15:0]};
		write_reg(cmd_reg, cmd);
		if (t_kind[n] == 2) begin
			read_reg(dxl_pkg::REG_STATUS, data);
			check_value("status busy", data[dxl_pkg::STAT_BUSY], 1);
			// held off until the first packet is fully out
			write_reg(cmd_reg, cmd);
			check_value("packets before second ack", packets_seen, 1);
		end
		do read_reg(dxl_pkg::REG_STATUS, data); while (data[dxl_pkg::STAT_BUSY]);
		check_value("status valid", data[dxl_pkg::STAT_VALID], t_valid[n]);
		check_value("status timeout", data[dxl_pkg::STAT_TIMEOUT], t_timeout[n]);
		check_value("status error byte", data[23:16], t_err[n]);
		check_value("status value", data[15:0], t_rvalue[n]);
	endtask

	initial begin
		void'($urandom(32'hbec2edc2));
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = 2'd0;
		wb_dat_w = '0;
		rx_line = 1'b1;
		load_golden();
		cycle_limit = 100;
		for (int n = 0; n < n_tests; n++) begin
			cycle_limit += (t_pcnt[n] * ((t_kind[n] == 2) ? 2 : 1) + t_rcnt[n]) *
				10 * BIT_CLKS + MAX_GAP_BITS * BIT_CLKS +
				dxl_pkg::REPLY_TIMEOUT_CYCLES + 2000;
		end
		wait (reset == 1'b0);
		@(negedge clock);
		for (int n = 0; n < n_tests; n++) begin
			packets_seen = 0;
			fork
				drive_host(n);
				run_servo(n);
			join
		end
		$display("TB PASSED");
		$finish;
	end

endmodule

/* bench/dxl_golden.txt */
# kind(0 write, 1 read, 2 write issued twice) id addr value pkt_count pkt_bytes...
# reply_count reply_bytes... exp_valid exp_timeout exp_error exp_value   (all hex)
0 01 0019 0001 0D FF FF FD 00 01 06 00 03 19 00 01 2F 62
00 1 0 00 0000
0 01 001E 0200 0E FF FF FD 00 01 07 00 03 1E 00 00 02 53 C5
00 1 0 00 0000
1 01 0025 0002 0E FF FF FD 00 01 07 00 02 25 00 02 00 2D 95
0D FF FF FD 00 01 06 00 55 00 34 12 A9 E3
1 0 00 1234
1 01 0025 0002 0E FF FF FD 00 01 07 00 02 25 00 02 00 2D 95
0D FF FF FD 00 01 06 00 55 00 34 12 A9 E4
0 0 00 1234
1 01 0025 0002 0E FF FF FD 00 01 07 00 02 25 00 02 00 2D 95
0D FF FF FD 00 02 06 00 55 00 34 12 A9 E3
0 0 00 0000
1 01 0025 0002 0E FF FF FD 00 01 07 00 02 25 00 02 00 2D 95
00 0 1 00 0000
2 01 0019 0001 0D FF FF FD 00 01 06 00 03 19 00 01 2F 62
00 1 0 00 0000

/* verilog.f */
hdl/dxl_pkg.sv
hdl/dxl_crc16.sv
hdl/dxl_uart_tx.sv
hdl/dxl_uart_rx.sv
hdl/dxl_controller.sv
hdl/dxl_bus_master.sv
bench/tb_clock.sv
bench/dxl_bus_master_chk.sv
bench/dxl_bus_master_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module dxl_bus_master_tb -f verilog.f -o sim_dxl

./obj_dir/sim_dxl > sim.log 2>&1 || true
cat sim.log

grep -q "TB PASSED" sim.log
